// File: common/softmax_config.svh
// ========================================
// softmax configuration
// widths and depths shared by the softmax
// normalizer datapath and its buffers
// ========================================

`ifndef SOFTMAX_CONFIG_SVH
`define SOFTMAX_CONFIG_SVH

`define SM_COEF_W      4
`define SM_EXP_W       16
// 15 nodes of up to 2^15 each
`define SM_SUM_W       20
`define SM_NODE_W      4
`define SM_ADDR_W      8
`define SM_WOI         1
`define SM_WOF         15
`define SM_ALPHA_W     (`SM_WOI + `SM_WOF)
`define SM_FIFO_DEPTH  16
`define SM_DIV_LAT     (`SM_ALPHA_W + 2)

`endif

// File: common/softmax_data_pkg.sv
// ========================================
// softmax data types
// exponents, sums, node counts, alphas and
// the divisor buffer word
// ========================================

`include "softmax_config.svh"

package softmax_data_pkg;

  typedef logic [`SM_EXP_W-1:0]   exp_t;
  typedef logic [`SM_SUM_W-1:0]   sum_t;
  typedef logic [`SM_NODE_W-1:0]  node_cnt_t;
  typedef logic [`SM_ALPHA_W-1:0] alpha_t;

  // one entry per finished subgraph
  typedef struct packed {
    node_cnt_t node_cnt;
    sum_t      sum;
  } dvsr_entry_t;

endpackage

// File: common/softmax_ctrl_pkg.sv
// ========================================
// softmax control types
// FSM states of the accumulator and the
// normalizer
// ========================================

package softmax_ctrl_pkg;

  // accumulator
  typedef enum logic {
    ACC_FETCH,
    ACC_RUN
  } accum_state_t;

  // normalizer
  typedef enum logic {
    NORM_LOAD,
    NORM_STREAM
  } norm_state_t;

endpackage

// File: logic/sync_fifo.sv
// ========================================
// synchronous FIFO
// register array with show-ahead output
// ========================================

`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  input  logic             wr,
  output logic             full,
  output logic [WIDTH-1:0] dout,
  input  logic             rd,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;
  assign full  = count == CNT_W'(DEPTH);
  assign empty = count == '0;
  // head entry always visible
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer and consumer must respect the flags
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
    else $error("sync_fifo: write while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
    else $error("sync_fifo: read while empty");

endmodule

// File: logic/fxp_div_pipe.sv
// ========================================
// pipelined fixed-point divider
// unsigned restoring division, one
// quotient bit per stage, stall on adv low
// ========================================

`timescale 1ns/1ps

module fxp_div_pipe #(
  parameter int DIVD_W = 16,
  parameter int DVSR_W = 20,
  parameter int FRAC_W = 15
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              adv,
  input  logic              vld_in,
  input  logic [DIVD_W-1:0] dividend,
  input  logic [DVSR_W-1:0] divisor,
  output logic              vld_out,
  output logic [FRAC_W:0]   quotient
);

  // one integer bit, the dividend never exceeds the divisor
  localparam int Q_W   = FRAC_W + 1;
  localparam int NUM_W = DIVD_W + FRAC_W;

  logic [NUM_W-1:0]  num_ext;
  logic              vld_q  [Q_W+1];
  // low numerator bits shift out, quotient bits shift in
  logic [Q_W-1:0]    nq_q   [Q_W+1];
  logic [DVSR_W-1:0] rem_q  [Q_W];
  logic [DVSR_W-1:0] dvsr_q [Q_W];

  assign num_ext = {dividend, {FRAC_W{1'b0}}};

  // ========================================
  // input register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q[0] <= 1'b0;
    end else if (adv) begin
      vld_q[0] <= vld_in;
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      rem_q[0]  <= DVSR_W'(num_ext >> Q_W);
      nq_q[0]   <= num_ext[Q_W-1:0];
      dvsr_q[0] <= divisor;
    end
  end

  // ========================================
  // quotient stages
  // ========================================
  for (genvar i = 1; i <= Q_W; i++) begin : g_stage
    logic [DVSR_W:0] trial;
    logic            ge;

    assign trial = {rem_q[i-1], nq_q[i-1][Q_W-1]};
    assign ge    = trial >= {1'b0, dvsr_q[i-1]};

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q[i] <= 1'b0;
      end else if (adv) begin
        vld_q[i] <= vld_q[i-1];
      end
    end

    always_ff @(posedge clk) begin
      if (adv) begin
        nq_q[i] <= {nq_q[i-1][Q_W-2:0], ge};
      end
    end

    // last stage needs no remainder or divisor
    if (i < Q_W) begin : g_carry
      always_ff @(posedge clk) begin
        if (adv) begin
          rem_q[i]  <= ge ? DVSR_W'(trial - {1'b0, dvsr_q[i-1]}) : DVSR_W'(trial);
          dvsr_q[i] <= dvsr_q[i-1];
        end
      end
    end
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_out <= 1'b0;
    end else if (adv) begin
      vld_out <= vld_q[Q_W];
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      quotient <= nq_q[Q_W];
    end
  end

endmodule

// File: softmax/softmax_accum.sv
// ========================================
// softmax accumulator
// fetches node counts, raises coefficients
// to powers of two, keeps the subgraph sum
// and fills dividend and divisor buffers
// ========================================

`timescale 1ns/1ps

`include "softmax_config.svh"

module softmax_accum (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [`SM_COEF_W-1:0]         coef_data,
  input  logic                          coef_empty,
  output logic                          coef_rd,
  output logic [`SM_ADDR_W-1:0]         num_node_addr,
  input  softmax_data_pkg::node_cnt_t   num_node_data,
  output softmax_data_pkg::exp_t        divd_din,
  output logic                          divd_wr,
  input  logic                          divd_full,
  output softmax_data_pkg::dvsr_entry_t dvsr_din,
  output logic                          dvsr_wr,
  input  logic                          dvsr_full
);

  softmax_ctrl_pkg::accum_state_t state;
  logic [`SM_ADDR_W-1:0]          addr_q;
  softmax_data_pkg::node_cnt_t    num_node_q;
  softmax_data_pkg::node_cnt_t    node_cnt_q;
  softmax_data_pkg::sum_t         sum_q;
  softmax_data_pkg::sum_t         sum_nxt;
  softmax_data_pkg::exp_t         exp_val;
  logic                           running;
  logic                           last_node;

  // ========================================
  // exponent and sum
  // ========================================
  // one-hot shift, coef 0 gives 1
  assign exp_val   = softmax_data_pkg::exp_t'(1) << coef_data;
  assign sum_nxt   = sum_q + softmax_data_pkg::sum_t'(exp_val);
  assign running   = state == softmax_ctrl_pkg::ACC_RUN;
  assign last_node = (node_cnt_q + 1'b1) == num_node_q;

  // divisor space only matters on the closing read
  assign coef_rd = running && en && !coef_empty && !divd_full
                   && (!last_node || !dvsr_full);

  assign divd_din      = exp_val;
  assign divd_wr       = coef_rd;
  assign dvsr_din      = '{node_cnt: num_node_q, sum: sum_nxt};
  assign dvsr_wr       = coef_rd && last_node;
  assign num_node_addr = addr_q;

  // ========================================
  // control
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= softmax_ctrl_pkg::ACC_FETCH;
      addr_q     <= '0;
      node_cnt_q <= '0;
    end else begin
      case (state)
        softmax_ctrl_pkg::ACC_FETCH: begin
          // memory answered the address by now
          state      <= softmax_ctrl_pkg::ACC_RUN;
          node_cnt_q <= '0;
        end
        softmax_ctrl_pkg::ACC_RUN: begin
          if (coef_rd) begin
            if (last_node) begin
              state  <= softmax_ctrl_pkg::ACC_FETCH;
              addr_q <= addr_q + 1'b1;
            end else begin
              node_cnt_q <= node_cnt_q + 1'b1;
            end
          end
        end
        default: state <= softmax_ctrl_pkg::ACC_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == softmax_ctrl_pkg::ACC_FETCH) begin
      num_node_q <= num_node_data;
      sum_q      <= '0;
    end else if (coef_rd) begin
      sum_q <= sum_nxt;
    end
  end

  // an empty subgraph would stall the normalizer forever
  a_node_cnt_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    (state == softmax_ctrl_pkg::ACC_FETCH) |-> (num_node_data != '0))
    else $error("softmax_accum: zero node count at address %0d", addr_q);

endmodule

// File: softmax/softmax_norm.sv
// ========================================
// softmax normalizer
// pairs each divisor entry with its
// dividends and streams them through the
// divider into the alpha FIFO
// ========================================

`timescale 1ns/1ps

`include "softmax_config.svh"

module softmax_norm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  softmax_data_pkg::exp_t        divd_dout,
  input  logic                          divd_empty,
  output logic                          divd_rd,
  input  softmax_data_pkg::dvsr_entry_t dvsr_dout,
  input  logic                          dvsr_empty,
  output logic                          dvsr_rd,
  input  logic                          alpha_full,
  output softmax_data_pkg::alpha_t      alpha_data,
  output logic                          alpha_wr
);

  softmax_ctrl_pkg::norm_state_t state;
  softmax_data_pkg::sum_t        sum_hold;
  softmax_data_pkg::node_cnt_t   num_hold;
  softmax_data_pkg::node_cnt_t   issue_cnt;
  logic                          last_issue;
  logic                          adv;
  logic                          div_vld_out;

  // alpha FIFO back-pressure freezes everything
  assign adv = !alpha_full;

  assign dvsr_rd    = (state == softmax_ctrl_pkg::NORM_LOAD) && !dvsr_empty;
  assign divd_rd    = (state == softmax_ctrl_pkg::NORM_STREAM) && !divd_empty && adv;
  assign last_issue = (issue_cnt + 1'b1) == num_hold;

  // ========================================
  // control
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= softmax_ctrl_pkg::NORM_LOAD;
      issue_cnt <= '0;
    end else begin
      case (state)
        softmax_ctrl_pkg::NORM_LOAD: begin
          if (dvsr_rd) begin
            state     <= softmax_ctrl_pkg::NORM_STREAM;
            issue_cnt <= '0;
          end
        end
        softmax_ctrl_pkg::NORM_STREAM: begin
          if (divd_rd) begin
            issue_cnt <= issue_cnt + 1'b1;
            if (last_issue) begin
              state <= softmax_ctrl_pkg::NORM_LOAD;
            end
          end
        end
        default: state <= softmax_ctrl_pkg::NORM_LOAD;
      endcase
    end
  end

  // current subgraph's divisor
  always_ff @(posedge clk) begin
    if (dvsr_rd) begin
      sum_hold <= dvsr_dout.sum;
      num_hold <= dvsr_dout.node_cnt;
    end
  end

  // ========================================
  // divider
  // ========================================
  fxp_div_pipe #(
    .DIVD_W   (`SM_EXP_W),
    .DVSR_W   (`SM_SUM_W),
    .FRAC_W   (`SM_WOF)
  ) u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .adv      (adv),
    .vld_in   (divd_rd),
    .dividend (divd_dout),
    .divisor  (sum_hold),
    .vld_out  (div_vld_out),
    .quotient (alpha_data)
  );

  assign alpha_wr = div_vld_out && !alpha_full;

  // sum built by the accumulator is never zero
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    divd_rd |-> (sum_hold != '0))
    else $error("softmax_norm: dividend issued with zero divisor");

endmodule

// File: softmax/softmax_top.sv
// ========================================
// softmax normalizer top
// accumulator, dividend and divisor
// buffers, normalizer
// ========================================

`timescale 1ns/1ps

`include "softmax_config.svh"

module softmax_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        en,
  input  logic [`SM_COEF_W-1:0]       coef_data,
  input  logic                        coef_empty,
  output logic                        coef_rd,
  output logic [`SM_ADDR_W-1:0]       num_node_addr,
  input  softmax_data_pkg::node_cnt_t num_node_data,
  output softmax_data_pkg::alpha_t    alpha_data,
  output logic                        alpha_wr,
  input  logic                        alpha_full
);

  // dividend buffer
  softmax_data_pkg::exp_t        divd_din;
  softmax_data_pkg::exp_t        divd_dout;
  logic                          divd_wr;
  logic                          divd_full;
  logic                          divd_rd;
  logic                          divd_empty;

  // divisor buffer
  softmax_data_pkg::dvsr_entry_t dvsr_din;
  softmax_data_pkg::dvsr_entry_t dvsr_dout;
  logic                          dvsr_wr;
  logic                          dvsr_full;
  logic                          dvsr_rd;
  logic                          dvsr_empty;

  softmax_accum u_accum (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .coef_data     (coef_data),
    .coef_empty    (coef_empty),
    .coef_rd       (coef_rd),
    .num_node_addr (num_node_addr),
    .num_node_data (num_node_data),
    .divd_din      (divd_din),
    .divd_wr       (divd_wr),
    .divd_full     (divd_full),
    .dvsr_din      (dvsr_din),
    .dvsr_wr       (dvsr_wr),
    .dvsr_full     (dvsr_full)
  );

  sync_fifo #(
    .WIDTH (`SM_EXP_W),
    .DEPTH (`SM_FIFO_DEPTH)
  ) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (divd_din),
    .wr    (divd_wr),
    .full  (divd_full),
    .dout  (divd_dout),
    .rd    (divd_rd),
    .empty (divd_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(softmax_data_pkg::dvsr_entry_t)),
    .DEPTH (`SM_FIFO_DEPTH)
  ) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (dvsr_din),
    .wr    (dvsr_wr),
    .full  (dvsr_full),
    .dout  (dvsr_dout),
    .rd    (dvsr_rd),
    .empty (dvsr_empty)
  );

  softmax_norm u_norm (
    .clk        (clk),
    .rst_n      (rst_n),
    .divd_dout  (divd_dout),
    .divd_empty (divd_empty),
    .divd_rd    (divd_rd),
    .dvsr_dout  (dvsr_dout),
    .dvsr_empty (dvsr_empty),
    .dvsr_rd    (dvsr_rd),
    .alpha_full (alpha_full),
    .alpha_data (alpha_data),
    .alpha_wr   (alpha_wr)
  );

endmodule

// File: tb/softmax_model.svh
// ========================================
// softmax reference model
// expected alphas, subgraph sizes, the
// node-count memory and the random source
// ========================================

`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

localparam logic [15:0] LFSR_SEED = 16'd64423;
// x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] LFSR_TAPS = 16'hB400;

// upstream coefficients in read order
logic [`SM_COEF_W-1:0]       coef_q[$];
// expected alphas in coefficient order
int unsigned                 alpha_q[$];
// node count of each subgraph
int unsigned                 sg_nodes_q[$];
softmax_data_pkg::node_cnt_t node_mem [1 << `SM_ADDR_W];

// one Galois step
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ LFSR_TAPS;
  end
  return n;
endfunction

// exponent over subgraph sum in 1.15, truncated
function automatic int unsigned golden_alpha(input int unsigned exp_val,
                                             input int unsigned sum);
  logic [63:0] num;
  num = 64'(exp_val) << `SM_WOF;
  return 32'(num / 64'(sum));
endfunction

`endif

// File: tb/softmax_tb.sv
// ========================================
// softmax normalizer testbench
// random subgraphs under upstream gaps,
// enable drops and alpha back-pressure
// ========================================

`timescale 1ns/1ps

`include "softmax_config.svh"

module softmax_tb;

  localparam int NUM_SG      = 200;
  localparam int CYCLE_LIMIT = NUM_SG * 15 * 8 + 1000;
  localparam int ONE_Q15     = 1 << `SM_WOF;

  logic                        clk;
  logic                        rst_n;
  logic                        en;
  logic [`SM_COEF_W-1:0]       coef_data;
  logic                        coef_empty;
  logic                        coef_rd;
  logic [`SM_ADDR_W-1:0]       num_node_addr;
  softmax_data_pkg::node_cnt_t num_node_data;
  softmax_data_pkg::alpha_t    alpha_data;
  logic                        alpha_wr;
  logic                        alpha_full;

  logic [15:0] lfsr_state;
  int          coef_ptr;
  int          result_cnt;
  int          sg_idx;
  int          sg_seen;
  int          sg_alpha_sum;
  int          cycle_cnt;
  int          value_errs;
  int          proto_errs;
  bit          timed_out;

  `include "softmax_model.svh"

  softmax_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .coef_data     (coef_data),
    .coef_empty    (coef_empty),
    .coef_rd       (coef_rd),
    .num_node_addr (num_node_addr),
    .num_node_data (num_node_data),
    .alpha_data    (alpha_data),
    .alpha_wr      (alpha_wr),
    .alpha_full    (alpha_full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // n bits, one lfsr step per bit
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  task automatic build_subgraphs();
    int unsigned n;
    int unsigned c;
    int unsigned sum;
    int unsigned exps[$];
    // entries past the last subgraph stay nonzero
    for (int a = 0; a < (1 << `SM_ADDR_W); a++) begin
      node_mem[a] = softmax_data_pkg::node_cnt_t'(a % 15 + 1);
    end
    for (int s = 0; s < NUM_SG; s++) begin
      // first subgraph is a single node
      n = (s == 0) ? 1 : 0;
      while (n == 0) begin
        n = rand_bits(4);
      end
      node_mem[s] = softmax_data_pkg::node_cnt_t'(n);
      sg_nodes_q.push_back(n);
      exps.delete();
      sum = 0;
      for (int k = 0; k < n; k++) begin
        c = rand_bits(`SM_COEF_W);
        coef_q.push_back(c[`SM_COEF_W-1:0]);
        exps.push_back(32'd1 << c);
        sum += 32'd1 << c;
      end
      foreach (exps[k]) begin
        alpha_q.push_back(golden_alpha(exps[k], sum));
      end
    end
  endtask

  // ========================================
  // falling edge drive, rising edge sample
  // ========================================
  task automatic drive_inputs();
    // memory answers the address seen this cycle
    num_node_data = node_mem[num_node_addr];
    en            = rand_bits(3) != 0;
    coef_empty    = (rand_bits(2) == 0) || (coef_ptr >= coef_q.size());
    coef_data     = (coef_ptr < coef_q.size()) ? coef_q[coef_ptr] : '0;
    alpha_full    = rand_bits(2) == 0;
  endtask

  task automatic sample_outputs();
    int unsigned expected;
    if (coef_rd) begin
      if (!en || coef_empty) begin
        $display("coef_rd high at %0t while en is low or the coefficient FIFO is empty", $time);
        proto_errs++;
      end else begin
        coef_ptr++;
      end
    end
    if (alpha_wr) begin
      if (alpha_full) begin
        $display("alpha_wr high at %0t while the alpha FIFO is full", $time);
        proto_errs++;
      end
      if (alpha_q.size() == 0) begin
        $display("alpha %0d written at %0t with no result pending", alpha_data, $time);
        proto_errs++;
      end else begin
        expected = alpha_q.pop_front();
        if (result_cnt == 0 && int'(alpha_data) != ONE_Q15) begin
          $display("** Error at %0t: single-node alpha expected %0d, got %0d",
                   $time, ONE_Q15, alpha_data);
          value_errs++;
        end
        if (32'(alpha_data) != expected) begin
          $display("** Error at %0t: alpha %0d expected %0d, got %0d",
                   $time, result_cnt, expected, alpha_data);
          value_errs++;
        end
        // truncation loses less than one lsb per node
        sg_alpha_sum += int'(alpha_data);
        sg_seen++;
        if (sg_seen == sg_nodes_q[sg_idx]) begin
          if (sg_alpha_sum > ONE_Q15 || sg_alpha_sum < ONE_Q15 - sg_seen) begin
            $display("** Error at %0t: subgraph %0d alphas add up to %0d, expected %0d to %0d",
                     $time, sg_idx, sg_alpha_sum, ONE_Q15 - sg_seen, ONE_Q15);
            value_errs++;
          end
          sg_idx++;
          sg_seen      = 0;
          sg_alpha_sum = 0;
        end
      end
      result_cnt++;
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    rst_n         = 1'b0;
    en            = 1'b0;
    coef_data     = '0;
    coef_empty    = 1'b1;
    num_node_data = '0;
    alpha_full    = 1'b0;
    lfsr_state    = LFSR_SEED;
    coef_ptr      = 0;
    result_cnt    = 0;
    sg_idx        = 0;
    sg_seen       = 0;
    sg_alpha_sum  = 0;
    cycle_cnt     = 0;
    value_errs    = 0;
    proto_errs    = 0;
    timed_out     = 1'b0;
    build_subgraphs();

    repeat (10) begin
      @(negedge clk);
      num_node_data = node_mem[num_node_addr];
    end
    rst_n = 1'b1;

    // quiet right after reset
    @(posedge clk);
    if (coef_rd || alpha_wr || num_node_addr != 0) begin
      $display("** Error at %0t: after reset coef_rd=%0b alpha_wr=%0b num_node_addr=%0d",
               $time, coef_rd, alpha_wr, num_node_addr);
      value_errs++;
    end

    while (result_cnt < coef_q.size() && cycle_cnt < CYCLE_LIMIT) begin
      @(negedge clk);
      drive_inputs();
      @(posedge clk);
      cycle_cnt++;
      sample_outputs();
    end

    if (result_cnt < coef_q.size()) begin
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d results after %0d cycles",
               result_cnt, coef_q.size(), cycle_cnt);
    end else begin
      // any extra result would show up here
      repeat (`SM_DIV_LAT + 4) begin
        @(negedge clk);
        drive_inputs();
        @(posedge clk);
        sample_outputs();
      end
    end

    if (alpha_q.size() != 0) begin
      $display("%0d expected results never arrived", alpha_q.size());
      proto_errs++;
    end
    if (coef_ptr != coef_q.size() || result_cnt != coef_ptr) begin
      $display("** Error at %0t: %0d coefficients read of %0d, %0d results",
               $time, coef_ptr, coef_q.size(), result_cnt);
      value_errs++;
    end
    if (num_node_addr != NUM_SG) begin
      $display("** Error at %0t: num_node_addr expected %0d, got %0d",
               $time, NUM_SG, num_node_addr);
      value_errs++;
    end

    $display("value errors: %0d, protocol errors: %0d, results: %0d of %0d",
             value_errs, proto_errs, result_cnt, coef_q.size());
    if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: softmax.f
+incdir+common
+incdir+tb
common/softmax_data_pkg.sv
common/softmax_ctrl_pkg.sv
logic/sync_fifo.sv
logic/fxp_div_pipe.sv
softmax/softmax_accum.sv
softmax/softmax_norm.sv
softmax/softmax_top.sv
tb/softmax_tb.sv

// File: Makefile
# Verilator build and run for the softmax normalizer

VERILATOR ?= verilator
TOP       ?= softmax_tb
FILELIST  ?= softmax.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)
